/* Bender.yml */
package:
  name: hist_tdc

sources:
  - files:
      - rtl/hist_cfg_pkg.sv
      - rtl/hist_bus_pkg.sv
      - rtl/hist_frame_counter.sv
      - rtl/hist_accumulator.sv
      - rtl/hist_readout.sv
      - rtl/hist_mem_arbiter.sv
      - rtl/hist_ram.sv
      - rtl/hist_top.sv
  - target: test
    files:
      - bench/hist_chk.sv
      - bench/hist_tb.sv

/* bench/hist_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module hist_chk import hist_cfg_pkg::*; import hist_bus_pkg::*; (
    input logic      clk,
    input logic      res,
    input wb_req_t   ram_req,
    input wb_rsp_t   ram_rsp,
    input wb_req_t   acc_req,
    input wb_rsp_t   acc_rsp,
    input wb_req_t   rdo_req,
    input wb_rsp_t   rdo_rsp,
    input logic      out_valid,
    input logic      out_ready,
    input hist_rec_t out_rec,
    input logic      bank_done,
    input logic      rdo_busy
);

    // sticky flag, testbench polls it through the bind instance
    logic err_seen = 1'b0;

    // registered ack answers the strobe of the previous cycle
    // master still holds stb, adr and we in the ack cycle
    ack_after_stb: assert property (@(posedge clk) disable iff (!res)
        ram_rsp.ack |-> $past(ram_req.cyc && ram_req.stb) && ram_req.cyc && ram_req.stb
                        && $stable(ram_req.adr) && $stable(ram_req.we))
    else begin
        $error("ram ack without a held strobe");
        err_seen = 1'b1;
    end

    // accumulator ack only while it strobes, never shared with the readout
    one_ack: assert property (@(posedge clk) disable iff (!res)
        acc_rsp.ack |-> acc_req.cyc && acc_req.stb && !rdo_rsp.ack)
    else begin
        $error("accumulator saw an ack it did not strobe for, or both masters did");
        err_seen = 1'b1;
    end

    // readout ack only while it strobes
    rdo_ack: assert property (@(posedge clk) disable iff (!res)
        rdo_rsp.ack |-> rdo_req.cyc && rdo_req.stb)
    else begin
        $error("readout saw an ack without its own strobe");
        err_seen = 1'b1;
    end

    // stalled record stays put and stays valid
    rec_hold: assert property (@(posedge clk) disable iff (!res)
        out_valid && !out_ready |=> out_valid && $stable(out_rec))
    else begin
        $error("out_rec changed or out_valid dropped during a stall");
        err_seen = 1'b1;
    end

    // hold must keep a new bank_done away from a busy drain
    done_idle: assert property (@(posedge clk) disable iff (!res)
        bank_done |-> !rdo_busy)
    else begin
        $error("bank_done while the readout is still busy");
        err_seen = 1'b1;
    end

endmodule

bind hist_top hist_chk u_chk (
    .clk      (clk),
    .res      (res),
    .ram_req  (ram_req),
    .ram_rsp  (ram_rsp),
    .acc_req  (acc_req),
    .acc_rsp  (acc_rsp),
    .rdo_req  (rdo_req),
    .rdo_rsp  (rdo_rsp),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_rec  (out_rec),
    .bank_done(bank_done),
    .rdo_busy (rdo_busy)
);

`default_nettype wire

/* bench/hist_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module hist_tb import hist_cfg_pkg::*; ();

    localparam int BIN_NUM        = 16;
    localparam int PIXEL_NUM      = 4;
    localparam int HITS_PER_PIXEL = 8;
    localparam int ACQ_NUM        = 3;
    localparam int BANK_HITS      = HITS_PER_PIXEL * PIXEL_NUM * ACQ_NUM;
    localparam int BANK_WORDS     = PIXEL_NUM * BIN_NUM;
    // sparse 1, random 3, hold 1, one bin 2
    localparam int BANK_FILLS     = 7;
    localparam int HIT_TOTAL      = BANK_FILLS * BANK_HITS;
    localparam int REC_TOTAL      = BANK_FILLS * BANK_WORDS;
    localparam int RESET_CYCLES   = 8;
    localparam int HOLD_CYCLES    = 30;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 * BANK_WORDS + HOLD_CYCLES
                                   + HIT_TOTAL * 20 + REC_TOTAL * 10;
    // out_ready behaviour
    localparam int RDY_LOW  = 0;
    localparam int RDY_HIGH = 1;
    localparam int RDY_RAND = 2;

    logic                 clk;
    logic                 res;
    logic                 hit_valid;
    logic [BIN_W_MAX-1:0] hit_bin;
    logic                 hit_ready;
    logic                 out_valid;
    hist_rec_t            out_rec;
    logic                 out_ready;
    logic                 bank_done;

    // reference histogram per bank, pixel and bin
    logic [COUNT_W-1:0] model [2][PIXEL_NUM][BIN_NUM];
    hist_rec_t          exp_q [$];
    int                 hit_idx    = 0;
    int                 pix_idx    = 0;
    int                 acq_idx    = 0;
    logic               mbank      = 1'b0;
    logic               done_due   = 1'b0;
    int                 hits_taken = 0;
    int                 rec_seen   = 0;
    int                 ready_mode = RDY_HIGH;
    string              test_name  = "reset";

    hist_top #(
        .BIN_NUM       (BIN_NUM),
        .PIXEL_NUM     (PIXEL_NUM),
        .HITS_PER_PIXEL(HITS_PER_PIXEL),
        .ACQ_NUM       (ACQ_NUM)
    ) DUT (
        .clk, .res, .hit_valid, .hit_bin, .hit_ready,
        .out_valid, .out_rec, .out_ready, .bank_done
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_fail(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] exp,
                                   input logic [63:0] act);
        stop_fail($sformatf("MISMATCH %s %s: expected %0h actual %0h",
                            test_name, what, exp, act));
    endtask

    // finished bank becomes the expected record list, then clears
    task automatic queue_bank(input logic b);
        hist_rec_t rec;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            for (int i = 0; i < BIN_NUM; i++) begin
                rec.bank  = b;
                rec.pixel = PIX_W_MAX'(p);
                rec.bin   = BIN_W_MAX'(i);
                rec.count = model[b][p][i];
                exp_q.push_back(rec);
                model[b][p][i] = '0;
            end
        end
    endtask

    // frame counter nesting of hits in pixels in acquisitions
    task automatic take_hit(input int bin);
        if (model[mbank][pix_idx][bin] != '1) begin
            model[mbank][pix_idx][bin] = model[mbank][pix_idx][bin] + 1'b1;
        end
        hits_taken++;
        hit_idx++;
        if (hit_idx == HITS_PER_PIXEL) begin
            hit_idx = 0;
            pix_idx++;
            if (pix_idx == PIXEL_NUM) begin
                pix_idx = 0;
                acq_idx++;
                if (acq_idx == ACQ_NUM) begin
                    acq_idx  = 0;
                    queue_bank(mbank);
                    mbank    = ~mbank;
                    // registered pulse, due on the next edge
                    done_due = 1'b1;
                end
            end
        end
    endtask

    task automatic check_record();
        hist_rec_t exp_rec;
        assert (exp_q.size() != 0)
            else stop_fail("a record came out with no bank waiting to drain");
        exp_rec = exp_q.pop_front();
        rec_seen++;
        assert (out_rec == exp_rec)
            else report_mismatch("record", 64'(exp_rec), 64'(out_rec));
    endtask

    // sampled on the edge, inputs move 1 ns later
    always @(posedge clk) begin
        if (res) begin
            assert (bank_done == done_due)
                else report_mismatch("bank_done", 64'(done_due), 64'(bank_done));
            done_due = 1'b0;
            assert (!DUT.u_chk.err_seen)
                else stop_fail("a bound protocol assertion failed");
            if (hit_valid && hit_ready) begin
                take_hit(int'(hit_bin));
            end
            if (out_valid && out_ready) begin
                check_record();
            end
        end
    end

    // next out_ready picked on the edge, applied after the hold time
    initial begin
        logic nxt;
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            case (ready_mode)
                RDY_LOW:  nxt = 1'b0;
                RDY_HIGH: nxt = 1'b1;
                default:  nxt = ($urandom % 4) != 0;
            endcase
            #1;
            out_ready = nxt;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_fail($sformatf("timeout: run not finished after %0d cycles in test %s",
                            WATCHDOG_CYCLES, test_name));
    end

    // one hit, optional idle gap first, returns 1 ns after acceptance
    task automatic send_hit(input int bin, input bit stall);
        int gap;
        gap = stall ? int'($urandom % 4) : 0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        hit_valid = 1'b1;
        hit_bin   = BIN_W_MAX'(bin);
        do begin
            @(posedge clk);
        end while (!hit_ready);
        #1;
        hit_valid = 1'b0;
    endtask

    initial begin
        void'($urandom(32'hfa9f));
        res       = 1'b0;
        hit_valid = 1'b0;
        hit_bin   = '0;
        for (int b = 0; b < 2; b++) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                for (int i = 0; i < BIN_NUM; i++) begin
                    model[b][p][i] = '0;
                end
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        res = 1'b1;
        // one dead cycle on hit_ready, outputs quiet
        @(posedge clk);
        assert (!hit_ready) else stop_fail("hit_ready high right after reset");
        assert (!out_valid && !bank_done)
            else stop_fail("out_valid or bank_done high right after reset");
        @(posedge clk);
        assert (hit_ready) else stop_fail("hit_ready still low after the init cycle");
        #1;

        // upper half of the bins never hit, must read back zero
        test_name = "sparse";
        repeat (BANK_HITS) send_hit($urandom % (BIN_NUM / 2), 1'b1);

        // both banks used twice, stalls on both sides
        test_name  = "random";
        ready_mode = RDY_RAND;
        repeat (3 * BANK_HITS) send_hit($urandom % BIN_NUM, 1'b1);

        // stuck drain across the next bank swap
        // last hit of the bank must wait for the drain
        test_name  = "hold";
        ready_mode = RDY_LOW;
        repeat (BANK_HITS - 1) send_hit($urandom % BIN_NUM, 1'b0);
        hit_valid = 1'b1;
        hit_bin   = BIN_W_MAX'($urandom % BIN_NUM);
        repeat (HOLD_CYCLES) begin
            @(posedge clk);
            assert (!hit_ready) else stop_fail("last hit accepted while the drain stalls");
        end
        #1;
        ready_mode = RDY_HIGH;
        do begin
            @(posedge clk);
        end while (!hit_ready);
        #1;
        hit_valid = 1'b0;

        // back to back on one bin, drain fights for the ram
        test_name  = "one_bin";
        ready_mode = RDY_RAND;
        repeat (2 * BANK_HITS) send_hit(BIN_NUM - 3, 1'b0);

        test_name = "drain";
        do begin
            @(posedge clk);
            #1;
        end while (rec_seen < REC_TOTAL);
        repeat (10) @(posedge clk);
        #1;
        if (exp_q.size() == 0 && hits_taken == HIT_TOTAL && !out_valid
            && !DUT.u_chk.err_seen) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            stop_fail("run ended with hits or records left over or a protocol error");
        end
    end

endmodule

`default_nettype wire

/* rtl/hist_accumulator.sv */
`timescale 1ns/1ps
`default_nettype none

module hist_accumulator import hist_cfg_pkg::*; import hist_bus_pkg::*; (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 hit_valid,
    input  logic [BIN_W_MAX-1:0] hit_bin,
    output logic                 hit_ready,
    output logic                 hit_take,
    input  logic [PIX_W_MAX-1:0] cur_pixel,
    input  logic                 fill_bank,
    input  logic                 hold,
    output wb_req_t              acc_req,
    input  wb_rsp_t              acc_rsp
);

    // init is the single dead cycle after reset
    typedef enum logic [2:0] {
        A_INIT,
        A_IDLE,
        A_READ,
        A_INC,
        A_WRITE
    } acc_state_t;

    acc_state_t         state;
    hist_addr_t         hit_adr;
    logic [COUNT_W-1:0] cnt_q;

    // ready only between hits and never under hold
    assign hit_ready = (state == A_IDLE) & ~hold;
    assign hit_take  = hit_valid & hit_ready;

    // cyc spans read, increment and write
    // the arbiter keeps us granted so the update is atomic
    assign acc_req.cyc = (state == A_READ) | (state == A_INC) | (state == A_WRITE);
    // stb low during increment, one access per strobe
    assign acc_req.stb = (state == A_READ) | (state == A_WRITE);
    assign acc_req.we  = (state == A_WRITE);
    assign acc_req.adr = hit_adr;
    assign acc_req.dat = cnt_q;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= A_INIT;
        end else begin
            case (state)
                A_INIT: state <= A_IDLE;
                A_IDLE: begin
                    if (hit_take) begin
                        state <= A_READ;
                    end
                end
                A_READ: begin
                    if (acc_rsp.ack) begin
                        state <= A_INC;
                    end
                end
                // one cycle to add with stb dropped
                A_INC: state <= A_WRITE;
                A_WRITE: begin
                    // write ack ends the hit
                    if (acc_rsp.ack) begin
                        state <= A_IDLE;
                    end
                end
                default: state <= A_INIT;
            endcase
        end
    end

    // address and count of the hit in flight
    always_ff @(posedge clk) begin
        if (hit_take) begin
            hit_adr <= '{bank: fill_bank, pixel: cur_pixel, bin: hit_bin};
        end
        if (state == A_READ && acc_rsp.ack) begin
            cnt_q <= acc_rsp.dat;
        end else if (state == A_INC && cnt_q != '1) begin
            // saturate at full scale
            cnt_q <= cnt_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/hist_bus_pkg.sv */
`default_nettype none

package hist_bus_pkg;

    import hist_cfg_pkg::*;

    // number of masters on the shared histogram ram
    localparam int MST_NUM = 2;

    // master index of the hit accumulator, wins when bus is free
    localparam logic MST_ACC = 1'b0;

    // master index of the readout and clear engine
    localparam logic MST_RDO = 1'b1;

    // wishbone classic master request
    // cyc frames a whole tenure, stb marks one access
    // adr, we and dat stay put until ack
    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic               we;
        hist_addr_t         adr;
        logic [COUNT_W-1:0] dat;
    } wb_req_t;

    // wishbone classic slave response
    // read data is valid in the ack cycle only
    typedef struct packed {
        logic               ack;
        logic [COUNT_W-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* rtl/hist_cfg_pkg.sv */
`default_nettype none

package hist_cfg_pkg;

    // time-bin index width, room for up to 64 bins
    localparam int BIN_W_MAX = 6;

    // pixel index width, up to 16 pixels per sweep
    localparam int PIX_W_MAX = 4;

    // one histogram count, saturates at all ones
    localparam int COUNT_W = 16;

    // ram word address, bank bit on top of pixel and bin
    localparam int HIST_ADDR_W = 1 + PIX_W_MAX + BIN_W_MAX;

    // word address into the histogram ram
    // bank is the ping-pong half, pixel and bin pick the word
    typedef struct packed {
        logic                 bank;
        logic [PIX_W_MAX-1:0] pixel;
        logic [BIN_W_MAX-1:0] bin;
    } hist_addr_t;

    // one readout record, address fields plus the count
    typedef struct packed {
        logic                 bank;
        logic [PIX_W_MAX-1:0] pixel;
        logic [BIN_W_MAX-1:0] bin;
        logic [COUNT_W-1:0]   count;
    } hist_rec_t;

endpackage

`default_nettype wire

/* rtl/hist_frame_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module hist_frame_counter import hist_cfg_pkg::*; #(
    parameter int HITS_PER_PIXEL = 8,
    parameter int PIXEL_NUM      = 4,
    parameter int ACQ_NUM        = 3
) (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 hit_take,
    input  logic                 rdo_busy,
    output logic [PIX_W_MAX-1:0] cur_pixel,
    output logic                 fill_bank,
    output logic                 bank_done,
    output logic                 hold
);

    // counter widths, at least one bit each
    localparam int HIT_W = (HITS_PER_PIXEL > 1) ? $clog2(HITS_PER_PIXEL) : 1;
    localparam int ACQ_W = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1;

    logic [HIT_W-1:0]     hit_cnt;
    logic [PIX_W_MAX-1:0] pix_cnt;
    logic [ACQ_W-1:0]     acq_cnt;
    logic                 last_hit;
    logic                 last_pix;
    logic                 last_acq;

    // end of each counter level
    assign last_hit = (hit_cnt == HIT_W'(HITS_PER_PIXEL - 1));
    assign last_pix = (pix_cnt == PIX_W_MAX'(PIXEL_NUM - 1));
    assign last_acq = (acq_cnt == ACQ_W'(ACQ_NUM - 1));

    // next hit would flip banks but old bank still draining
    assign hold = last_hit & last_pix & last_acq & rdo_busy;

    // accumulator tags each hit with this pixel
    assign cur_pixel = pix_cnt;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hit_cnt   <= '0;
            pix_cnt   <= '0;
            acq_cnt   <= '0;
            fill_bank <= 1'b0;
            bank_done <= 1'b0;
        end else begin
            // single cycle pulse
            bank_done <= 1'b0;
            if (hit_take) begin
                if (!last_hit) begin
                    hit_cnt <= hit_cnt + 1'b1;
                end else begin
                    // pixel full, move to the next one
                    hit_cnt <= '0;
                    if (!last_pix) begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end else begin
                        // sweep over all pixels done
                        pix_cnt <= '0;
                        if (!last_acq) begin
                            acq_cnt <= acq_cnt + 1'b1;
                        end else begin
                            // acquisition complete, swap banks
                            acq_cnt   <= '0;
                            fill_bank <= ~fill_bank;
                            bank_done <= 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/hist_mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module hist_mem_arbiter import hist_bus_pkg::*; (
    input  logic    clk,
    input  logic    res,
    input  wb_req_t acc_req,
    output wb_rsp_t acc_rsp,
    input  wb_req_t rdo_req,
    output wb_rsp_t rdo_rsp,
    output wb_req_t ram_req,
    input  wb_rsp_t ram_rsp
);

    wb_req_t req [MST_NUM];
    wb_rsp_t rsp [MST_NUM];
    // owner of the current tenure
    logic    own;
    logic    own_vld;
    // master routed to the ram this cycle
    logic    sel;

    assign req[MST_ACC] = acc_req;
    assign req[MST_RDO] = rdo_req;

    // owner keeps the bus while its cyc stays high
    // otherwise fixed priority, accumulator first
    always_comb begin
        if (own_vld && req[own].cyc) begin
            sel = own;
        end else if (acc_req.cyc) begin
            sel = MST_ACC;
        end else begin
            sel = MST_RDO;
        end
    end

    // idle readout request has cyc low, so an empty bus stays idle
    assign ram_req = req[sel];

    // ack and data only to the selected master
    always_comb begin
        for (int i = 0; i < MST_NUM; i++) begin
            rsp[i] = '0;
        end
        rsp[sel] = ram_rsp;
    end

    assign acc_rsp = rsp[MST_ACC];
    assign rdo_rsp = rsp[MST_RDO];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            own     <= MST_ACC;
            own_vld <= 1'b0;
        end else begin
            // tenure lasts while the granted cyc is up
            own     <= sel;
            own_vld <= ram_req.cyc;
        end
    end

endmodule

`default_nettype wire

/* rtl/hist_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module hist_ram import hist_cfg_pkg::*; import hist_bus_pkg::*; #(
    parameter int BIN_NUM   = 16,
    parameter int PIXEL_NUM = 4
) (
    input  logic    clk,
    input  logic    res,
    input  wb_req_t ram_req,
    output wb_rsp_t ram_rsp
);

    // both banks in one single-port array
    logic [COUNT_W-1:0] mem [2**HIST_ADDR_W];
    logic               ack_q;
    logic [COUNT_W-1:0] dat_q;
    // zeroing walk over every used word after reset
    logic               clearing;
    hist_addr_t         clr_adr;
    logic               clr_bin_last;
    logic               clr_pix_last;
    logic               access;

    assign clr_bin_last = (clr_adr.bin == BIN_W_MAX'(BIN_NUM - 1));
    assign clr_pix_last = (clr_adr.pixel == PIX_W_MAX'(PIXEL_NUM - 1));

    // one access per strobe, masters simply wait out the clear
    assign access  = ram_req.cyc & ram_req.stb & ~ack_q & ~clearing;
    assign ram_rsp = '{ack: ack_q, dat: dat_q};

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            ack_q    <= 1'b0;
            clearing <= 1'b1;
            clr_adr  <= '0;
        end else begin
            // registered ack one cycle after the strobe
            ack_q <= access;
            if (clearing) begin
                if (clr_bin_last) begin
                    clr_adr.bin <= '0;
                    if (clr_pix_last) begin
                        clr_adr.pixel <= '0;
                        // bank 1 finished ends the walk
                        clearing      <= ~clr_adr.bank;
                        clr_adr.bank  <= 1'b1;
                    end else begin
                        clr_adr.pixel <= clr_adr.pixel + 1'b1;
                    end
                end else begin
                    clr_adr.bin <= clr_adr.bin + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clr_adr] <= '0;
        end else if (access && ram_req.we) begin
            mem[ram_req.adr] <= ram_req.dat;
        end
        // read data lines up with ack
        if (access && !ram_req.we) begin
            dat_q <= mem[ram_req.adr];
        end
    end

endmodule

`default_nettype wire

/* rtl/hist_readout.sv */
`timescale 1ns/1ps
`default_nettype none

module hist_readout import hist_cfg_pkg::*; import hist_bus_pkg::*; #(
    parameter int BIN_NUM   = 16,
    parameter int PIXEL_NUM = 4
) (
    input  logic      clk,
    input  logic      res,
    input  logic      bank_done,
    input  logic      drain_bank,
    output logic      rdo_busy,
    output wb_req_t   rdo_req,
    input  wb_rsp_t   rdo_rsp,
    output logic      out_valid,
    output hist_rec_t out_rec,
    input  logic      out_ready
);

    // read, show, clear, then a bus-free gap before next word
    typedef enum logic [2:0] {
        R_IDLE,
        R_READ,
        R_SHOW,
        R_CLEAR,
        R_NEXT
    } rdo_state_t;

    rdo_state_t state;
    hist_addr_t scan_adr;
    logic       scan_last;

    // last word of the drained bank
    assign scan_last = (scan_adr.pixel == PIX_W_MAX'(PIXEL_NUM - 1)) &
                       (scan_adr.bin == BIN_W_MAX'(BIN_NUM - 1));

    assign rdo_busy  = (state != R_IDLE);
    assign out_valid = (state == R_SHOW);

    // bus is released while the record waits on out_ready
    assign rdo_req.cyc = (state == R_READ) | (state == R_CLEAR);
    assign rdo_req.stb = (state == R_READ) | (state == R_CLEAR);
    assign rdo_req.we  = (state == R_CLEAR);
    assign rdo_req.adr = scan_adr;
    // clear writes zero
    assign rdo_req.dat = '0;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state    <= R_IDLE;
            scan_adr <= '0;
        end else begin
            case (state)
                R_IDLE: begin
                    // start at pixel 0 bin 0 of the finished bank
                    if (bank_done) begin
                        scan_adr <= '{bank: drain_bank, pixel: '0, bin: '0};
                        state    <= R_READ;
                    end
                end
                R_READ: begin
                    if (rdo_rsp.ack) begin
                        state <= R_SHOW;
                    end
                end
                R_SHOW: begin
                    if (out_ready) begin
                        state <= R_CLEAR;
                    end
                end
                R_CLEAR: begin
                    // done once the final zero is in
                    if (rdo_rsp.ack) begin
                        state <= scan_last ? R_IDLE : R_NEXT;
                    end
                end
                R_NEXT: begin
                    // bin runs fastest, then pixel
                    if (scan_adr.bin == BIN_W_MAX'(BIN_NUM - 1)) begin
                        scan_adr.bin   <= '0;
                        scan_adr.pixel <= scan_adr.pixel + 1'b1;
                    end else begin
                        scan_adr.bin <= scan_adr.bin + 1'b1;
                    end
                    state <= R_READ;
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    // record captured with the read ack, held through the stall
    always_ff @(posedge clk) begin
        if (state == R_READ && rdo_rsp.ack) begin
            out_rec <= '{bank: scan_adr.bank, pixel: scan_adr.pixel,
                         bin: scan_adr.bin, count: rdo_rsp.dat};
        end
    end

endmodule

`default_nettype wire

/* rtl/hist_top.sv */
`timescale 1ns/1ps
`default_nettype none

module hist_top import hist_cfg_pkg::*; import hist_bus_pkg::*; #(
    parameter int BIN_NUM        = 16,
    parameter int PIXEL_NUM      = 4,
    parameter int HITS_PER_PIXEL = 8,
    parameter int ACQ_NUM        = 3
) (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 hit_valid,
    input  logic [BIN_W_MAX-1:0] hit_bin,
    output logic                 hit_ready,
    output logic                 out_valid,
    output hist_rec_t            out_rec,
    input  logic                 out_ready,
    output logic                 bank_done
);

    logic                 hit_take;
    logic                 rdo_busy;
    logic                 hold;
    logic                 fill_bank;
    logic                 drain_bank;
    logic [PIX_W_MAX-1:0] cur_pixel;
    wb_req_t              acc_req;
    wb_rsp_t              acc_rsp;
    wb_req_t              rdo_req;
    wb_rsp_t              rdo_rsp;
    wb_req_t              ram_req;
    wb_rsp_t              ram_rsp;

    // readout always drains the bank not being filled
    assign drain_bank = ~fill_bank;

    hist_frame_counter #(
        .HITS_PER_PIXEL(HITS_PER_PIXEL),
        .PIXEL_NUM     (PIXEL_NUM),
        .ACQ_NUM       (ACQ_NUM)
    ) u_frame (
        .clk, .res, .hit_take, .rdo_busy, .cur_pixel, .fill_bank, .bank_done, .hold
    );

    hist_accumulator u_acc (
        .clk, .res, .hit_valid, .hit_bin, .hit_ready, .hit_take,
        .cur_pixel, .fill_bank, .hold, .acc_req, .acc_rsp
    );

    hist_readout #(
        .BIN_NUM  (BIN_NUM),
        .PIXEL_NUM(PIXEL_NUM)
    ) u_rdo (
        .clk, .res, .bank_done, .drain_bank, .rdo_busy, .rdo_req, .rdo_rsp,
        .out_valid, .out_rec, .out_ready
    );

    hist_mem_arbiter u_arb (
        .clk, .res, .acc_req, .acc_rsp, .rdo_req, .rdo_rsp, .ram_req, .ram_rsp
    );

    hist_ram #(
        .BIN_NUM  (BIN_NUM),
        .PIXEL_NUM(PIXEL_NUM)
    ) u_ram (
        .clk, .res, .ram_req, .ram_rsp
    );

endmodule

`default_nettype wire

/* tb.f */
rtl/hist_cfg_pkg.sv
rtl/hist_bus_pkg.sv
rtl/hist_frame_counter.sv
rtl/hist_accumulator.sv
rtl/hist_readout.sv
rtl/hist_mem_arbiter.sv
rtl/hist_ram.sv
rtl/hist_top.sv
bench/hist_chk.sv
bench/hist_tb.sv
